/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_ahb_input_stage
FILELIST   := build.f
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/ahb_ip_pkg.sv
rtl/ahb_ip_hold.sv
rtl/ahb_ip_resp.sv
rtl/ahb_ip_burst.sv
rtl/ahb_input_stage.sv
sim/ahb_input_stage_asserts.sv
sim/tb_ahb_input_stage.sv

/* rtl/ahb_input_stage.sv */
// AHB bus matrix slave port input stage holding transfers for the output stage
`default_nettype none

module ahb_input_stage
#(
  parameter int ADDR_WIDTH = ahb_ip_pkg::ADDR_WIDTH_DEFAULT
)
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  // Master side address phase
  input  logic                  hsel,
  input  logic [ADDR_WIDTH-1:0] haddr,
  input  ahb_ip_pkg::htrans_t   htrans,
  input  logic                  hwrite,
  input  ahb_ip_pkg::hsize_t    hsize,
  input  ahb_ip_pkg::hburst_t   hburst,
  input  logic                  hmastlock,
  input  logic                  hready,
  // Output stage response
  input  logic                  active_ip,
  input  logic                  readyout_ip,
  input  ahb_ip_pkg::hresp_t    resp_ip,
  // Master side response
  output logic                  hreadyout,
  output ahb_ip_pkg::hresp_t    hresp,
  // Toward output stage
  output logic                  sel_ip,
  output logic [ADDR_WIDTH-1:0] addr_ip,
  output ahb_ip_pkg::htrans_t   trans_ip,
  output logic                  write_ip,
  output ahb_ip_pkg::hsize_t    size_ip,
  output ahb_ip_pkg::hburst_t   burst_ip,
  output logic                  mastlock_ip,
  output logic                  held_tran_ip
);

  import ahb_ip_pkg::*;

  logic    load_reg;       // Address phase accepted
  logic    addr_valid;
  logic    pend_tran_reg;  // Transfer waiting for output stage
  htrans_t trans_sel;
  htrans_t trans_int;
  hburst_t burst_int;

  // Holding register and mux
  ahb_ip_hold #(.ADDR_WIDTH(ADDR_WIDTH)) i_ahb_ip_hold
  (
    .HCLK, .HRESETn, .hsel, .haddr, .htrans, .hwrite, .hsize, .hburst,
    .hmastlock, .hready, .active_ip, .readyout_ip,
    .sel_ip, .addr_ip, .write_ip, .size_ip, .mastlock_ip, .held_tran_ip,
    .load_reg, .addr_valid, .pend_tran_reg, .trans_sel, .trans_int, .burst_int
  );

  // Master response
  ahb_ip_resp i_ahb_ip_resp
  (
    .HCLK, .HRESETn, .hready, .addr_valid, .pend_tran_reg,
    .readyout_ip, .resp_ip, .hreadyout, .hresp
  );

  // Broken burst fix-up
  ahb_ip_burst #(.ADDR_WIDTH(ADDR_WIDTH)) i_ahb_ip_burst
  (
    .HCLK, .HRESETn, .htrans, .haddr, .hsize, .hburst, .hready,
    .load_reg, .active_ip, .trans_sel, .trans_int, .burst_int,
    .trans_ip, .burst_ip
  );

endmodule

`default_nettype wire

/* rtl/ahb_ip_burst.sv */
// AHB input stage early burst termination with HTRANS/HBURST override
`default_nettype none

module ahb_ip_burst
#(
  parameter int ADDR_WIDTH = 32
)
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_ip_pkg::htrans_t   htrans,
  input  logic [ADDR_WIDTH-1:0] haddr,
  input  ahb_ip_pkg::hsize_t    hsize,
  input  ahb_ip_pkg::hburst_t   hburst,
  input  logic                  hready,
  input  logic                  load_reg,
  input  logic                  active_ip,
  input  ahb_ip_pkg::htrans_t   trans_sel,  // Held or direct HTRANS
  input  ahb_ip_pkg::htrans_t   trans_int,  // HTRANS after hold mux
  input  ahb_ip_pkg::hburst_t   burst_int,  // HBURST after hold mux
  output ahb_ip_pkg::htrans_t   trans_ip,
  output ahb_ip_pkg::hburst_t   burst_ip
);

  import ahb_ip_pkg::*;

  logic                  burst_override;  // Burst was broken off
  logic                  burst_override_next;
  logic [BOUND_BITS-1:0] offset_addr;     // Beat number within a WRAP16
  logic [BOUND_BITS-1:0] check_addr;      // All ones on last beat of a wrap
  logic                  bound;           // Previous beat ended a wrap
  logic                  bound_en;

  // -------------------------------------------------------------------------
  // Override flag
  // -------------------------------------------------------------------------

  // A new burst or idle ends it, a SEQ taken without the output stage starts it
  always_comb
  begin
    if (htrans == NONSEQ || htrans == IDLE)
      burst_override_next = 1'b0;
    else if (htrans == SEQ && load_reg && !active_ip)
      burst_override_next = 1'b1;
    else
      burst_override_next = burst_override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (hready)
      burst_override <= burst_override_next;
  end

  // -------------------------------------------------------------------------
  // Wrap boundary check
  // -------------------------------------------------------------------------

  always_comb
  begin
    case (hsize)
      SIZE_BYTE:  offset_addr = haddr[BOUND_BITS-1:0];
      SIZE_HALF:  offset_addr = haddr[BOUND_BITS:1];
      SIZE_WORD:  offset_addr = haddr[BOUND_BITS+1:2];
      SIZE_DWORD: offset_addr = haddr[BOUND_BITS+2:3];
      default:    offset_addr = haddr[BOUND_BITS-1:0];  // Wider sizes unsupported
    endcase
  end

  // Upper bits forced high so only the wrap's own beat bits are compared
  always_comb
  begin
    case (hburst)
      WRAP4:   check_addr = {{(BOUND_BITS-2){1'b1}}, offset_addr[1:0]};
      WRAP8:   check_addr = {{(BOUND_BITS-3){1'b1}}, offset_addr[2:0]};
      WRAP16:  check_addr = offset_addr;
      default: check_addr = '0;  // Incrementing and single never wrap
    endcase
  end

  assign bound_en = htrans[1] & hready;  // Only on accepted active beats

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= &check_addr;
  end

  // SEQ -> NONSEQ and BUSY -> IDLE past a wrap boundary
  assign trans_ip = (burst_override && bound) ? htrans_t'({trans_int[1], 1'b0}) : trans_int;

  // Rest of a broken burst goes out as undefined-length
  assign burst_ip = (burst_override && trans_sel != NONSEQ) ? INCR : burst_int;

endmodule

`default_nettype wire

/* rtl/ahb_ip_hold.sv */
// AHB input stage holding register, pending-transfer flag and held/direct address mux
`default_nettype none

module ahb_ip_hold
#(
  parameter int ADDR_WIDTH = 32
)
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  hsel,
  input  logic [ADDR_WIDTH-1:0] haddr,
  input  ahb_ip_pkg::htrans_t   htrans,
  input  logic                  hwrite,
  input  ahb_ip_pkg::hsize_t    hsize,
  input  ahb_ip_pkg::hburst_t   hburst,
  input  logic                  hmastlock,
  input  logic                  hready,
  input  logic                  active_ip,    // Output stage owned by this port
  input  logic                  readyout_ip,  // Slave ready via output stage
  output logic                  sel_ip,
  output logic [ADDR_WIDTH-1:0] addr_ip,
  output logic                  write_ip,
  output ahb_ip_pkg::hsize_t    size_ip,
  output logic                  mastlock_ip,
  output logic                  held_tran_ip, // Request to arbitration
  output logic                  load_reg,
  output logic                  addr_valid,
  output logic                  pend_tran_reg,
  output ahb_ip_pkg::htrans_t   trans_sel,    // HTRANS for burst decisions
  output ahb_ip_pkg::htrans_t   trans_int,
  output ahb_ip_pkg::hburst_t   burst_int
);

  import ahb_ip_pkg::*;

  // Captured address phase
  htrans_t               reg_trans;
  logic [ADDR_WIDTH-1:0] reg_addr;
  logic                  reg_write;
  hsize_t                reg_size;
  hburst_t               reg_burst;
  logic                  reg_mastlock;

  // -------------------------------------------------------------------------
  // Accept and capture
  // -------------------------------------------------------------------------

  assign addr_valid = hsel & htrans[1];     // NONSEQ or SEQ to this port
  assign load_reg   = addr_valid & hready;  // Master moves past address phase

  // Loaded on every accept, only read while a transfer waits
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_trans    <= htrans;
      reg_addr     <= haddr;
      reg_write    <= hwrite;
      reg_size     <= hsize;
      reg_burst    <= hburst;
      reg_mastlock <= hmastlock;
    end
  end

  // Set when the output stage missed the accept, cleared once it completes
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else if (load_reg && !active_ip)
      pend_tran_reg <= 1'b1;
    else if (active_ip && readyout_ip)
      pend_tran_reg <= 1'b0;
  end

  // Request stays up while the transfer sits in the register
  assign held_tran_ip = load_reg | pend_tran_reg;

  // -------------------------------------------------------------------------
  // Held / direct mux
  // -------------------------------------------------------------------------

  always_comb
  begin
    if (pend_tran_reg)
    begin
      sel_ip      = 1'b1;       // Held transfer is always selected
      trans_int   = NONSEQ;     // Restarts as a fresh transfer
      addr_ip     = reg_addr;
      write_ip    = reg_write;
      size_ip     = reg_size;
      burst_int   = reg_burst;
      mastlock_ip = reg_mastlock;
    end
    else
    begin
      sel_ip      = hsel;
      trans_int   = htrans;
      addr_ip     = haddr;
      write_ip    = hwrite;
      size_ip     = hsize;
      burst_int   = hburst;
      mastlock_ip = hmastlock;
    end
  end

  // Original HTRANS of the held beat, not the forced NONSEQ
  assign trans_sel = pend_tran_reg ? reg_trans : htrans;

endmodule

`default_nettype wire

/* rtl/ahb_ip_pkg.sv */
// AHB input stage encodings for transfer type, burst, size and response
`default_nettype none

package ahb_ip_pkg;

  // -------------------------------------------------------------------------
  // AHB bus encodings
  // -------------------------------------------------------------------------

  // HTRANS
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,  // No transfer wanted
    BUSY   = 2'b01,  // Master stalls inside a burst
    NONSEQ = 2'b10,  // Single or first beat
    SEQ    = 2'b11   // Following burst beats
  } htrans_t;

  // HBURST
  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // HSIZE, only byte to doubleword have a beat offset of their own
  typedef logic [2:0] hsize_t;

  localparam hsize_t SIZE_BYTE  = 3'd0;
  localparam hsize_t SIZE_HALF  = 3'd1;
  localparam hsize_t SIZE_WORD  = 3'd2;
  localparam hsize_t SIZE_DWORD = 3'd3;

  // HRESP
  typedef enum logic [1:0]
  {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_t;

  localparam int BOUND_BITS         = 4;   // Beats covered by a WRAP16
  localparam int ADDR_WIDTH_DEFAULT = 32;

endpackage

`default_nettype wire

/* rtl/ahb_ip_resp.sv */
// AHB input stage data-phase tracking and HREADYOUT/HRESP back to the master
`default_nettype none

module ahb_ip_resp
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               hready,
  input  logic               addr_valid,    // Valid address phase this cycle
  input  logic               pend_tran_reg, // Transfer waiting in hold register
  input  logic               readyout_ip,   // Slave HREADYOUT
  input  ahb_ip_pkg::hresp_t resp_ip,       // Slave HRESP
  output logic               hreadyout,
  output ahb_ip_pkg::hresp_t hresp
);

  import ahb_ip_pkg::*;

  logic data_valid;  // Data phase of a valid transfer

  // Address phase turns into data phase when the master sees HREADY
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (hready)
      data_valid <= addr_valid;
  end

  // Three sources for the response
  always_comb
  begin
    if (!data_valid)
    begin
      hreadyout = 1'b1;         // Idle, busy or not selected
      hresp     = OKAY;
    end
    else if (pend_tran_reg)
    begin
      hreadyout = 1'b0;         // Wait states until output stage is granted
      hresp     = OKAY;
    end
    else
    begin
      hreadyout = readyout_ip;  // Slave answers directly
      hresp     = resp_ip;
    end
  end

endmodule

`default_nettype wire

/* sim/ahb_input_stage_asserts.sv */
// AHB input stage concurrent checks on master response and held-transfer request
`default_nettype none

module ahb_input_stage_asserts
(
  input logic               HCLK,
  input logic               HRESETn,
  input logic               load_reg,       // Address phase accepted
  input logic               pend_tran_reg,  // Transfer waiting in hold register
  input logic               held_tran_ip,
  input logic               hreadyout,
  input ahb_ip_pkg::hresp_t hresp
);

  import ahb_ip_pkg::*;

  int unsigned fail_count = 0;  // Assertion failures so far

  // Wait states for a held transfer never carry a response
  a_held_wait_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (pend_tran_reg && !hreadyout) |-> (hresp == OKAY))
    else
    begin
      fail_count++;
      $error("hresp not OKAY during held-transfer wait state");
    end

  // Arbitration sees the request in the accept cycle itself
  a_request_on_load: assert property (@(posedge HCLK) disable iff (!HRESETn)
    load_reg |-> held_tran_ip)
    else
    begin
      fail_count++;
      $error("held_tran_ip low while an address phase is accepted");
    end

  a_ready_after_reset: assert property (@(posedge HCLK)
    !HRESETn |=> hreadyout)
    else
    begin
      fail_count++;
      $error("hreadyout not high after reset");
    end

endmodule

bind ahb_input_stage ahb_input_stage_asserts i_ahb_input_stage_asserts
(
  .HCLK(HCLK), .HRESETn(HRESETn), .load_reg(load_reg), .pend_tran_reg(pend_tran_reg),
  .held_tran_ip(held_tran_ip), .hreadyout(hreadyout), .hresp(hresp)
);

`default_nettype wire

/* sim/tb_ahb_input_stage.sv */
// Directed testbench for the AHB bus matrix input stage
`default_nettype none

module tb_ahb_input_stage;

  import ahb_ip_pkg::*;

  localparam int ADDR_WIDTH     = ADDR_WIDTH_DEFAULT;
  localparam int CLK_PERIOD     = 8;
  localparam int SETTLE         = 2;    // Sample point after the falling edge
  localparam int RESET_CYCLES   = 16;
  localparam int TEST_CYCLES    = 150;  // Rough length of all tests
  localparam int TIMEOUT_CYCLES = (TEST_CYCLES + 50) * 10;  // Reset and slack, ten times over
  localparam logic [31:0] SEED  = 32'h5302_3b62;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  hsel;
  logic [ADDR_WIDTH-1:0] haddr;
  htrans_t               htrans;
  logic                  hwrite;
  hsize_t                hsize;
  hburst_t               hburst;
  logic                  hmastlock;
  logic                  hready;
  logic                  active_ip;
  logic                  readyout_ip;
  hresp_t                resp_ip;
  logic                  hreadyout;
  hresp_t                hresp;
  logic                  sel_ip;
  logic [ADDR_WIDTH-1:0] addr_ip;
  htrans_t               trans_ip;
  logic                  write_ip;
  hsize_t                size_ip;
  hburst_t               burst_ip;
  logic                  mastlock_ip;
  logic                  held_tran_ip;

  string  test_name;
  int     cycle_count;
  logic   next_write;  // Attributes applied at the next drive
  hsize_t next_size;
  logic   next_lock;

  ahb_input_stage #(.ADDR_WIDTH(ADDR_WIDTH)) i_ahb_input_stage (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // Watchdog
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge HCLK);
      cycle_count++;
    end
    abort_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // --------------------------------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %b actual %b", test_name, what, exp, act));
  endtask

  task automatic check_trans(input string what, input htrans_t exp, input htrans_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %s actual %s (%b)",
                          test_name, what, exp.name(), act.name(), act));
  endtask

  task automatic check_burst(input string what, input hburst_t exp, input hburst_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %s actual %s (%b)",
                          test_name, what, exp.name(), act.name(), act));
  endtask

  task automatic check_resp(input string what, input hresp_t exp, input hresp_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %s actual %s (%b)",
                          test_name, what, exp.name(), act.name(), act));
  endtask

  task automatic check_size(input string what, input hsize_t exp, input hsize_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %0d actual %0d", test_name, what, exp, act));
  endtask

  task automatic check_addr(input string what, input logic [ADDR_WIDTH-1:0] exp,
                            input logic [ADDR_WIDTH-1:0] act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act));
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // One cycle of master and output-stage inputs, then wait for outputs to settle
  task automatic drive(input logic sel, input htrans_t trans, input logic [ADDR_WIDTH-1:0] addr,
                       input hburst_t burst, input logic rdy, input logic act,
                       input logic slv_rdy, input hresp_t slv_resp);
    @(negedge HCLK);
    hsel        = sel;
    htrans      = trans;
    haddr       = addr;
    hburst      = burst;
    hready      = rdy;
    active_ip   = act;
    readyout_ip = slv_rdy;
    resp_ip     = slv_resp;
    hwrite      = next_write;
    hsize       = next_size;
    hmastlock   = next_lock;
    #SETTLE;
  endtask

  task automatic drive_idle();
    drive(1'b0, IDLE, '0, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
  endtask

  // Inputs stay as they are until the data phase completes
  task automatic wait_ready();
    while (hreadyout !== 1'b1)
    begin
      @(negedge HCLK);
      #SETTLE;
    end
  endtask

  task automatic check_no_response();
    check_bit("hreadyout", 1'b1, hreadyout);
    check_resp("hresp", OKAY, hresp);
    check_bit("held_tran_ip", 1'b0, held_tran_ip);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_pass_through();
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           rnd;
    test_name  = "pass_through";
    addr       = $urandom;
    rnd        = $urandom;
    next_write = rnd[0];
    next_lock  = rnd[1];
    next_size  = SIZE_WORD;
    drive(1'b1, NONSEQ, addr, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
    check_bit("sel_ip", 1'b1, sel_ip);
    check_addr("addr_ip", addr, addr_ip);
    check_trans("trans_ip", NONSEQ, trans_ip);
    check_bit("write_ip", rnd[0], write_ip);
    check_size("size_ip", SIZE_WORD, size_ip);
    check_burst("burst_ip", SINGLE, burst_ip);
    check_bit("mastlock_ip", rnd[1], mastlock_ip);
    check_bit("held_tran_ip", 1'b1, held_tran_ip);  // Request raised even when granted
    // Slave inserts a wait state, then answers ERROR
    drive(1'b0, IDLE, '0, SINGLE, 1'b0, 1'b1, 1'b0, OKAY);
    check_bit("hreadyout", 1'b0, hreadyout);
    check_resp("hresp", OKAY, hresp);
    drive(1'b0, IDLE, '0, SINGLE, 1'b1, 1'b1, 1'b1, ERROR);
    check_bit("hreadyout", 1'b1, hreadyout);
    check_resp("hresp", ERROR, hresp);
    drive_idle();
    check_no_response();
  endtask

  task automatic test_idle_unselected();
    test_name = "idle_unselected";
    drive(1'b0, NONSEQ, $urandom, INCR, 1'b1, 1'b1, 1'b0, ERROR);  // Not selected
    check_no_response();
    drive(1'b1, IDLE, $urandom, INCR, 1'b1, 1'b1, 1'b0, ERROR);
    check_no_response();
    drive(1'b1, BUSY, $urandom, INCR, 1'b1, 1'b1, 1'b0, ERROR);
    check_no_response();
    drive(1'b0, IDLE, '0, SINGLE, 1'b1, 1'b1, 1'b0, ERROR);
    check_no_response();
  endtask

  task automatic test_held_transfer();
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           rnd;
    test_name  = "held_transfer";
    addr       = $urandom;
    rnd        = $urandom;
    next_write = rnd[0];
    next_lock  = rnd[1];
    next_size  = SIZE_HALF;
    drive(1'b1, NONSEQ, addr, INCR, 1'b1, 1'b0, 1'b0, OKAY);  // Output stage busy elsewhere
    check_bit("held_tran_ip", 1'b1, held_tran_ip);
    // Master inputs move on, outputs must keep the captured phase
    next_write = ~rnd[0];
    next_lock  = ~rnd[1];
    next_size  = SIZE_BYTE;
    repeat (3)
    begin
      drive(1'b0, IDLE, ~addr, SINGLE, 1'b0, 1'b0, 1'b0, ERROR);
      check_bit("sel_ip", 1'b1, sel_ip);
      check_trans("trans_ip", NONSEQ, trans_ip);
      check_addr("addr_ip", addr, addr_ip);
      check_bit("write_ip", rnd[0], write_ip);
      check_size("size_ip", SIZE_HALF, size_ip);
      check_burst("burst_ip", INCR, burst_ip);
      check_bit("mastlock_ip", rnd[1], mastlock_ip);
      check_bit("held_tran_ip", 1'b1, held_tran_ip);
      check_bit("hreadyout", 1'b0, hreadyout);
      check_resp("hresp", OKAY, hresp);
    end
    // Grant for one edge, then back to the live inputs
    drive(1'b0, IDLE, ~addr, SINGLE, 1'b0, 1'b1, 1'b1, OKAY);
    wait_ready();
    check_bit("sel_ip", 1'b0, sel_ip);
    check_trans("trans_ip", IDLE, trans_ip);
    check_addr("addr_ip", ~addr, addr_ip);
    check_bit("write_ip", ~rnd[0], write_ip);
    check_bit("held_tran_ip", 1'b0, held_tran_ip);
    drive_idle();
  endtask

  task automatic test_broken_incr();
    logic [ADDR_WIDTH-1:0] base;
    test_name = "broken_incr";
    base      = $urandom & 32'hFFFF_FFF0;
    next_size = SIZE_WORD;
    drive(1'b1, NONSEQ, base, INCR4, 1'b1, 1'b1, 1'b1, OKAY);
    check_burst("burst_ip", INCR4, burst_ip);
    drive(1'b1, SEQ, base + 4, INCR4, 1'b1, 1'b0, 1'b1, OKAY);  // Taken without output stage
    check_trans("trans_ip", SEQ, trans_ip);
    check_burst("burst_ip", INCR4, burst_ip);
    drive(1'b1, SEQ, base + 8, INCR4, 1'b0, 1'b0, 1'b1, OKAY);
    check_trans("trans_ip", NONSEQ, trans_ip);  // Held beat restarts
    check_burst("burst_ip", INCR, burst_ip);
    drive(1'b1, SEQ, base + 8, INCR4, 1'b0, 1'b1, 1'b1, OKAY);
    wait_ready();
    check_trans("trans_ip", SEQ, trans_ip);
    check_burst("burst_ip", INCR, burst_ip);
    drive(1'b1, SEQ, base + 8, INCR4, 1'b1, 1'b1, 1'b1, OKAY);
    check_burst("burst_ip", INCR, burst_ip);
    drive(1'b1, NONSEQ, base + 32, INCR4, 1'b1, 1'b1, 1'b1, OKAY);
    check_trans("trans_ip", NONSEQ, trans_ip);
    check_burst("burst_ip", INCR4, burst_ip);  // New burst keeps its own type
    drive_idle();
    drive_idle();
  endtask

  task automatic test_broken_wrap();
    logic [ADDR_WIDTH-1:0] base;
    test_name = "broken_wrap";
    base      = $urandom & 32'hFFFF_FFF0;  // Word beat offset equals addr[3:2]
    next_size = SIZE_WORD;
    drive(1'b1, NONSEQ, base, WRAP4, 1'b1, 1'b1, 1'b1, OKAY);
    drive(1'b1, SEQ, base + 4, WRAP4, 1'b1, 1'b0, 1'b1, OKAY);  // Offset 1 sets the override
    drive(1'b1, SEQ, base + 8, WRAP4, 1'b0, 1'b0, 1'b1, OKAY);
    drive(1'b1, SEQ, base + 8, WRAP4, 1'b0, 1'b1, 1'b1, OKAY);
    wait_ready();
    check_trans("trans_ip", SEQ, trans_ip);  // No boundary after offset 1
    drive(1'b1, SEQ, base + 8, WRAP4, 1'b1, 1'b1, 1'b1, OKAY);
    check_trans("trans_ip", SEQ, trans_ip);
    drive(1'b1, SEQ, base + 12, WRAP4, 1'b1, 1'b1, 1'b1, OKAY);  // Offset 3, last beat
    check_trans("trans_ip", SEQ, trans_ip);
    drive(1'b1, BUSY, base, WRAP4, 1'b1, 1'b1, 1'b1, OKAY);
    check_trans("trans_ip", IDLE, trans_ip);
    drive(1'b1, SEQ, base, WRAP4, 1'b1, 1'b1, 1'b1, OKAY);
    check_trans("trans_ip", NONSEQ, trans_ip);
    check_burst("burst_ip", INCR, burst_ip);
    drive_idle();
    drive_idle();
    check_burst("burst_ip", SINGLE, burst_ip);  // Override gone after IDLE
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial
  begin
    HRESETn     = 1'b0;
    hsel        = 1'b0;
    haddr       = '0;
    htrans      = IDLE;
    hwrite      = 1'b0;
    hsize       = SIZE_WORD;
    hburst      = SINGLE;
    hmastlock   = 1'b0;
    hready      = 1'b1;
    active_ip   = 1'b1;
    readyout_ip = 1'b1;
    resp_ip     = OKAY;
    next_write  = 1'b0;
    next_size   = SIZE_WORD;
    next_lock   = 1'b0;
    test_name   = "reset";
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    drive_idle();
    check_no_response();
    test_pass_through();
    test_idle_unselected();
    test_held_transfer();
    test_broken_incr();
    test_broken_wrap();
    if (i_ahb_input_stage.i_ahb_input_stage_asserts.fail_count == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
      abort_run("A bound concurrent assertion failed during the run");
  end

endmodule

`default_nettype wire
